// File: run.sh
#!/usr/bin/env bash
# Builds the shading path testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module shade_tb \
	-f shade_top.f \
	-o shade_sim

# Bound assertions raise $error, the testbench ends the run with $fatal
./obj_dir/shade_sim +verilator+error+limit+20

// File: shade_top.f
+incdir+source
source/shade_pkg.sv
source/shade_if.sv
source/add16sat.sv
source/shade_regs.sv
source/add_array.sv
source/phrase_out.sv
source/shade_top.sv
verif/tb_clock.sv
verif/shade_assert.sv
verif/shade_tb.sv

// File: source/add16sat.sv
// One lane adder with word, byte and nibble carry splits and clamping, used per lane by add_array
`default_nettype none
`timescale 1ns/1ps

module add16sat import shade_pkg::*; (
	output logic [15:0] r,
	output logic        co,
	input  logic [15:0] a,
	input  logic [15:0] b,
	input  logic        cin,
	input  logic        sat,
	input  shade_mode_e mode
);

	logic        eightbit;
	logic        nibble;
	logic [9:0]  sum_lo;
	logic [17:0] sum_word;
	logic [8:0]  sum_hi;
	logic [4:0]  sum_top;
	logic        btop;
	logic        ctop;
	logic        saturate;
	logic        hisaturate;

	// Anything other than word mode splits at the byte
	assign eightbit = (mode != MODE_WORD);
	assign nibble = (mode == MODE_NIBBLE);

	// Carry in rides as an extra low bit on both operands
	// so each sum is a plain two-operand add
	assign sum_lo = {1'b0, a[7:0], cin} + {1'b0, b[7:0], cin};
	assign sum_word = {1'b0, a, cin} + {1'b0, b, cin};

	// High byte on its own, no carry from the low byte
	assign sum_hi = {1'b0, a[15:8]} + {1'b0, b[15:8]};

	// Top nibble on its own for nibble mode
	assign sum_top = {1'b0, a[15:12]} + {1'b0, b[15:12]};

	// Carry out follows the topmost active adder
	assign co = nibble ? sum_top[4] :
		eightbit ? sum_hi[8] : sum_word[17];

	// Sign of increment and carry at the clamped field's top
	assign btop = eightbit ? b[7] : b[15];
	assign ctop = eightbit ? sum_lo[9] : co;

	// Unsigned value stepped by signed increment overflows
	// when carry disagrees with the increment sign
	assign saturate = sat & (btop ^ ctop);

	// High byte only clamps in word mode
	assign hisaturate = ~eightbit & saturate;

	// Clamp is all ones on carry, all zeros otherwise
	assign r[7:0] = saturate ? {8{ctop}} : sum_lo[8:1];

	assign r[11:8] = hisaturate ? {4{ctop}} :
		eightbit ? sum_hi[3:0] : sum_word[12:9];

	// Nibble mode keeps the top nibble free of bit 11 carry
	assign r[15:12] = hisaturate ? {4{ctop}} :
		nibble ? sum_top[3:0] :
		eightbit ? sum_hi[7:4] : sum_word[16:13];

endmodule

`default_nettype wire

// File: source/add_array.sv
// Four lane accumulators with their adders and the chain carry wiring, fed by the sequencer
`include "shade_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module add_array import shade_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	shade_step_if.dst step_bus,
	shade_res_if.src  res_bus
);

	lane_vec_t                acc;
	lane_vec_t                sum;
	logic [`SHADE_LANES-1:0]  co;
	logic [`SHADE_LANES-1:0]  cin;
	logic [`SHADE_LANES-1:0]  lane_sat;

	genvar i;

	// Odd lanes are integer parts, even lanes fractions when chained
	for (i = 0; i < `SHADE_LANES; i++) begin : g_lane
		if (i % 2 == 1) begin : g_int
			// Carry from the fraction lane below
			assign cin[i] = step_bus.chain & co[i-1];
			assign lane_sat[i] = step_bus.sat;
		end else begin : g_frac
			assign cin[i] = 1'b0;
			// Fraction lane wraps so its carry reaches the integer lane
			assign lane_sat[i] = step_bus.sat & ~step_bus.chain;
		end

		add16sat u_add (
			.r    (sum[i]),
			.co   (co[i]),
			.a    (acc[i]),
			.b    (step_bus.inc[i]),
			.cin  (cin[i]),
			.sat  (lane_sat[i]),
			.mode (step_bus.mode)
		);
	end

	// Accumulators, base on load, adder result on step
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (step_bus.load) begin
			acc <= step_bus.base;
		end else if (step_bus.step) begin
			acc <= sum;
		end
	end

	// Valid lines up with the updated accumulators
	always_ff @(posedge clk) begin
		if (reset) begin
			res_bus.valid <= 1'b0;
			res_bus.last <= 1'b0;
		end else begin
			res_bus.valid <= step_bus.step;
			res_bus.last <= step_bus.step & step_bus.last;
		end
	end

	assign res_bus.lanes = acc;

endmodule

`default_nettype wire

// File: source/phrase_out.sv
// Output stage that registers each lane result as a 64-bit phrase with valid and done pulses
`include "shade_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module phrase_out import shade_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	shade_res_if.dst                 res_bus,
	output logic [`SHADE_PHRASE-1:0] phrase,
	output logic                     phrase_valid,
	output logic                     done
);

	// Phrase holds its value between results
	always_ff @(posedge clk) begin
		if (reset) begin
			phrase <= '0;
		end else if (res_bus.valid) begin
			// Lane 0 lands in bits 15:0
			phrase <= res_bus.lanes;
		end
	end

	// One valid per result, done on the last
	always_ff @(posedge clk) begin
		if (reset) begin
			phrase_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			phrase_valid <= res_bus.valid;
			done <= res_bus.valid & res_bus.last;
		end
	end

endmodule

`default_nettype wire

// File: source/shade_cfg.svh
// Shading data path sizes, included by the package and by any RTL that sizes vectors
`default_nettype none

`ifndef SHADE_CFG_SVH
`define SHADE_CFG_SVH

// Lanes per phrase
`define SHADE_LANES 4

// Bits per lane accumulator
`define SHADE_WIDTH 16

// Output phrase, all lanes side by side
`define SHADE_PHRASE 64

// Step counter width, taken from the low byte of a go write
`define SHADE_COUNT_W 8

`endif

`default_nettype wire

// File: source/shade_if.sv
// Internal buses of the shading path: step control into the adder array, results out of it
`default_nettype none
`timescale 1ns/1ps

// Sequencer to adder array
interface shade_step_if import shade_pkg::*; ();
	// One-cycle pulse, accumulators take base
	logic        load;
	// One-cycle pulse per step
	logic        step;
	// Marks the final step of a run
	logic        last;
	shade_mode_e mode;
	logic        sat;
	// Pairs lanes 0/1 and 2/3
	logic        chain;
	lane_vec_t   base;
	lane_vec_t   inc;

	modport src (output load, step, last, mode, sat, chain, base, inc);
	modport dst (input load, step, last, mode, sat, chain, base, inc);
endinterface

// Adder array to phrase output
interface shade_res_if import shade_pkg::*; ();
	// Pulses in the cycle after each step edge
	logic      valid;
	// Result of the final step
	logic      last;
	// Accumulator contents
	lane_vec_t lanes;

	modport src (output valid, last, lanes);
	modport dst (input valid, last, lanes);
endinterface

`default_nettype wire

// File: source/shade_pkg.sv
// Shared types for the shading data path, imported by the interfaces and the RTL modules
`include "shade_cfg.svh"
`default_nettype none

package shade_pkg;

	// Lane arithmetic mode, value 3 behaves as byte mode
	typedef enum logic [1:0] {
		MODE_WORD   = 2'd0,
		MODE_BYTE   = 2'd1,
		MODE_NIBBLE = 2'd2
	} shade_mode_e;

	// Register bus addresses
	typedef enum logic [3:0] {
		REG_BASE0 = 4'd0,
		REG_BASE1 = 4'd1,
		REG_BASE2 = 4'd2,
		REG_BASE3 = 4'd3,
		REG_INC0  = 4'd4,
		REG_INC1  = 4'd5,
		REG_INC2  = 4'd6,
		REG_INC3  = 4'd7,
		REG_CTRL  = 4'd8,
		REG_GO    = 4'd9
	} shade_reg_e;

	// Four lanes, lane 0 in the low bits
	typedef logic [`SHADE_LANES-1:0][`SHADE_WIDTH-1:0] lane_vec_t;

endpackage

`default_nettype wire

// File: source/shade_regs.sv
// Register bus decode, lane start and increment storage and step sequencer of the shading path
`include "shade_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module shade_regs import shade_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          reg_write,
	input  shade_reg_e    reg_addr,
	input  logic [15:0]   reg_data,
	output logic          busy,
	shade_step_if.src     step_bus
);

	// Result drains through two registers after the last step
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_STEP,
		ST_RESULT,
		ST_PHRASE
	} state_e;

	state_e                    state;
	logic [3:0]                addr_bits;
	logic [`SHADE_COUNT_W-1:0] rem;
	logic [`SHADE_COUNT_W-1:0] go_count;
	logic                      go;
	lane_vec_t                 base_r;
	lane_vec_t                 inc_r;
	shade_mode_e               mode_r;
	logic                      sat_r;
	logic                      chain_r;

	assign addr_bits = reg_addr;
	assign go_count = reg_data[`SHADE_COUNT_W-1:0];

	// Go only counts when idle and with a nonzero count
	assign go = reg_write && (reg_addr == REG_GO) && (state == ST_IDLE) && (go_count != '0);

	// Register file, writable during a run
	always_ff @(posedge clk) begin
		if (reset) begin
			base_r <= '0;
			inc_r <= '0;
			mode_r <= MODE_WORD;
			sat_r <= 1'b0;
			chain_r <= 1'b0;
		end else if (reg_write) begin
			case (reg_addr)
				REG_BASE0, REG_BASE1, REG_BASE2, REG_BASE3: begin
					base_r[addr_bits[1:0]] <= reg_data;
				end
				REG_INC0, REG_INC1, REG_INC2, REG_INC3: begin
					inc_r[addr_bits[1:0]] <= reg_data;
				end
				REG_CTRL: begin
					mode_r <= shade_mode_e'(reg_data[1:0]);
					sat_r <= reg_data[2];
					chain_r <= reg_data[3];
				end
				// Go handled by the sequencer, other addresses dropped
				default: begin
				end
			endcase
		end
	end

	// Sequencer: one load pulse, then rem step pulses
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			rem <= '0;
			step_bus.load <= 1'b0;
			step_bus.step <= 1'b0;
			step_bus.last <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (go) begin
						rem <= go_count;
						step_bus.load <= 1'b1;
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					step_bus.load <= 1'b0;
					step_bus.step <= 1'b1;
					step_bus.last <= (rem == 1);
					rem <= rem - 1'b1;
					state <= ST_STEP;
				end
				ST_STEP: begin
					if (step_bus.last) begin
						step_bus.step <= 1'b0;
						step_bus.last <= 1'b0;
						state <= ST_RESULT;
					end else begin
						step_bus.last <= (rem == 1);
						rem <= rem - 1'b1;
					end
				end
				// Last result sits in the accumulators
				ST_RESULT: state <= ST_PHRASE;
				// Last phrase and done are out
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign busy = (state != ST_IDLE);

	assign step_bus.base = base_r;
	assign step_bus.inc = inc_r;
	assign step_bus.mode = mode_r;
	assign step_bus.sat = sat_r;
	assign step_bus.chain = chain_r;

endmodule

`default_nettype wire

// File: source/shade_top.sv
// Top level of the shading data path, register bus in and phrases out on plain ports
`include "shade_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module shade_top import shade_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	// Register bus, every strobe taken at once
	input  logic                     reg_write,
	input  logic [3:0]               reg_addr,
	input  logic [15:0]              reg_data,
	// High from go until the cycle after done
	output logic                     busy,
	// Phrase stream, present only while valid
	output logic [`SHADE_PHRASE-1:0] phrase,
	output logic                     phrase_valid,
	output logic                     done
);

	// Sequencer to adders
	shade_step_if step_bus ();

	// Adders to phrase register
	shade_res_if res_bus ();

	// Bus decode and step sequencer
	shade_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.reg_write (reg_write),
		.reg_addr  (shade_reg_e'(reg_addr)),
		.reg_data  (reg_data),
		.busy      (busy),
		.step_bus  (step_bus)
	);

	// Lane adders and accumulators
	add_array u_array (
		.clk      (clk),
		.reset    (reset),
		.step_bus (step_bus),
		.res_bus  (res_bus)
	);

	// Phrase register, valid and done
	phrase_out u_out (
		.clk          (clk),
		.reset        (reset),
		.res_bus      (res_bus),
		.phrase       (phrase),
		.phrase_valid (phrase_valid),
		.done         (done)
	);

endmodule

`default_nettype wire

// File: verif/shade_assert.sv
// Lane arithmetic and timing model with assertions, bound into shade_top by the testbench build
`include "shade_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module shade_assert import shade_pkg::*; (
	input logic                     clk,
	input logic                     reset,
	input logic                     reg_write,
	input logic [3:0]               reg_addr,
	input logic [15:0]              reg_data,
	input logic                     busy,
	input logic [`SHADE_PHRASE-1:0] phrase,
	input logic                     phrase_valid,
	input logic                     done
);

	logic [63:0] base_m;
	logic [63:0] inc_m;
	logic [63:0] acc_m;
	logic [63:0] exp_phrase;
	logic [1:0]  mode_m;
	logic        sat_m;
	logic        chain_m;
	logic        ld_m;
	logic        busy_m;
	logic        upd;
	logic        upd_last;
	logic        exp_valid;
	logic        exp_done;
	logic [7:0]  left_m;
	logic        go_ok;
	// Watched by the testbench top
	logic        fail_seen = 1'b0;

	// One lane step, carry out in bit 16
	function automatic logic [16:0] lane_next(input logic [15:0] a, input logic [15:0] b,
		input logic cin, input logic sat, input logic [1:0] mode);
		logic [16:0] w;
		logic [8:0]  lo;
		logic [8:0]  hi;
		logic [4:0]  top;
		logic [15:0] r;
		w = {1'b0, a} + {1'b0, b} + {16'd0, cin};
		lo = {1'b0, a[7:0]} + {1'b0, b[7:0]} + {8'd0, cin};
		hi = {1'b0, a[15:8]} + {1'b0, b[15:8]};
		top = {1'b0, a[15:12]} + {1'b0, b[15:12]};
		if (mode == MODE_WORD) begin
			r = w[15:0];
			// Clamp when carry disagrees with the increment sign
			if (sat && (b[15] != w[16]))
				r = {16{w[16]}};
			return {w[16], r};
		end
		// Split modes: low byte clamps, high byte wraps
		r = {hi[7:0], lo[7:0]};
		if (sat && (b[7] != lo[8]))
			r[7:0] = {8{lo[8]}};
		if (mode == MODE_NIBBLE) begin
			r[11:8] = a[11:8] + b[11:8];
			r[15:12] = top[3:0];
			return {top[4], r};
		end
		return {hi[8], r};
	endfunction

	// All four lanes, fraction lanes feed integer lanes when chained
	function automatic logic [63:0] step_all(input logic [63:0] acc, input logic [63:0] inc,
		input logic [1:0] mode, input logic sat, input logic chain);
		logic [16:0] f0;
		logic [16:0] i1;
		logic [16:0] f2;
		logic [16:0] i3;
		f0 = lane_next(acc[15:0], inc[15:0], 1'b0, sat & ~chain, mode);
		i1 = lane_next(acc[31:16], inc[31:16], chain & f0[16], sat, mode);
		f2 = lane_next(acc[47:32], inc[47:32], 1'b0, sat & ~chain, mode);
		i3 = lane_next(acc[63:48], inc[63:48], chain & f2[16], sat, mode);
		return {i3[15:0], f2[15:0], i1[15:0], f0[15:0]};
	endfunction

	assign go_ok = reg_write && (reg_addr == REG_GO) && !busy_m && (reg_data[7:0] != 8'd0);

	// Shadow of the register file
	always_ff @(posedge clk) begin
		if (reset) begin
			base_m <= '0;
			inc_m <= '0;
			mode_m <= 2'd0;
			sat_m <= 1'b0;
			chain_m <= 1'b0;
		end else if (reg_write) begin
			if (reg_addr < 4'd4)
				base_m[{reg_addr[1:0], 4'h0} +: 16] <= reg_data;
			else if (reg_addr < 4'd8)
				inc_m[{reg_addr[1:0], 4'h0} +: 16] <= reg_data;
			else if (reg_addr == REG_CTRL)
				{chain_m, sat_m, mode_m} <= reg_data[3:0];
		end
	end

	// Run timing: load one edge after go, then one step per edge
	always_ff @(posedge clk) begin
		if (reset) begin
			ld_m <= 1'b0;
			busy_m <= 1'b0;
			left_m <= 8'd0;
			acc_m <= '0;
			upd <= 1'b0;
			upd_last <= 1'b0;
			exp_valid <= 1'b0;
			exp_done <= 1'b0;
			exp_phrase <= '0;
		end else begin
			ld_m <= go_ok;
			upd <= 1'b0;
			upd_last <= 1'b0;
			if (go_ok) begin
				busy_m <= 1'b1;
				left_m <= reg_data[7:0];
			end
			if (ld_m) begin
				acc_m <= base_m;
			end else if (left_m != 8'd0) begin
				acc_m <= step_all(acc_m, inc_m, mode_m, sat_m, chain_m);
				left_m <= left_m - 8'd1;
				upd <= 1'b1;
				upd_last <= (left_m == 8'd1);
			end
			// Phrase register sits one edge behind the accumulator
			exp_valid <= upd;
			exp_done <= upd_last;
			if (upd)
				exp_phrase <= acc_m;
			if (exp_done)
				busy_m <= 1'b0;
		end
	end

	a_busy: assert property (@(posedge clk) disable iff (reset) busy == busy_m)
	else begin
		fail_seen = 1'b1;
		$error("busy differs from the model");
	end

	a_valid: assert property (@(posedge clk) disable iff (reset) phrase_valid == exp_valid)
	else begin
		fail_seen = 1'b1;
		$error("phrase_valid differs from the model");
	end

	a_done: assert property (@(posedge clk) disable iff (reset) done == exp_done)
	else begin
		fail_seen = 1'b1;
		$error("done differs from the model");
	end

	a_phrase: assert property (@(posedge clk) disable iff (reset)
		exp_valid |-> phrase == exp_phrase)
	else begin
		fail_seen = 1'b1;
		$error("phrase %h, model %h", phrase, exp_phrase);
	end

endmodule

bind shade_top shade_assert u_assert (
	.clk          (clk),
	.reset        (reset),
	.reg_write    (reg_write),
	.reg_addr     (reg_addr),
	.reg_data     (reg_data),
	.busy         (busy),
	.phrase       (phrase),
	.phrase_valid (phrase_valid),
	.done         (done)
);

`default_nettype wire

// File: verif/shade_tb.sv
// Testbench top for the shading path, programs lanes and runs steps while bound assertions check
`include "shade_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module shade_tb import shade_pkg::*; ();

	logic                     clk;
	logic                     reset;
	logic                     reg_write = 1'b0;
	logic [3:0]               reg_addr = 4'd0;
	logic [15:0]              reg_data = 16'd0;
	logic                     busy;
	logic [`SHADE_PHRASE-1:0] phrase;
	logic                     phrase_valid;
	logic                     done;

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	shade_top uut (
		.clk          (clk),
		.reset        (reset),
		.reg_write    (reg_write),
		.reg_addr     (reg_addr),
		.reg_data     (reg_data),
		.busy         (busy),
		.phrase       (phrase),
		.phrase_valid (phrase_valid),
		.done         (done)
	);

	// First assertion failure ends the run
	always @(posedge clk) begin
		if (uut.u_assert.fail_seen) begin
			$display("FAIL %0t: assertion in shade_assert failed", $time);
			$display("test failed");
			$fatal(1, "stopped on assertion failure");
		end
	end

	// Called at a rising edge, returns one edge later
	task automatic write_reg(input shade_reg_e addr, input logic [15:0] data);
		reg_write <= 1'b1;
		reg_addr <= addr;
		reg_data <= data;
		@(posedge clk);
		reg_write <= 1'b0;
	endtask

	task automatic load_lanes(input logic [63:0] base, input logic [63:0] inc,
		input logic [3:0] ctrl);
		for (int i = 0; i < `SHADE_LANES; i++) begin
			write_reg(shade_reg_e'(i), base[i*16 +: 16]);
			write_reg(shade_reg_e'(i + 4), inc[i*16 +: 16]);
		end
		// mode in 1:0, sat in 2, chain in 3
		write_reg(REG_CTRL, {12'd0, ctrl});
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		while (!done) begin
			if (n == limit) begin
				$display("Timed out waiting for done");
				$display("test failed");
				$fatal(1, "done timeout");
			end
			@(posedge clk);
			n++;
		end
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (busy || reset) begin
			if (n == limit) begin
				$display("Timed out waiting for busy or reset to fall");
				$display("test failed");
				$fatal(1, "idle timeout");
			end
			@(posedge clk);
			n++;
		end
	endtask

	task automatic run_steps(input logic [7:0] count);
		write_reg(REG_GO, {8'd0, count});
		wait_done(count + 20);
		wait_idle(10);
	endtask

	// Anchor value with a few random low bits
	function automatic logic [15:0] jitter(input logic [15:0] anchor);
		return anchor + 16'($urandom % 64);
	endfunction

	initial begin
		logic [63:0] base;
		logic [63:0] inc;
		logic [7:0]  count;
		void'($urandom(32'hb6fe_8931));
		@(posedge clk);
		wait_idle(20);

		// Idle after reset, nothing may move
		repeat (10) @(posedge clk);

		// Word mode, plain wrap
		repeat (3) begin
			base = {$urandom, $urandom};
			inc = {$urandom, $urandom};
			count = 8'(1 + $urandom % 8);
			load_lanes(base, inc, 4'b0000);
			run_steps(count);
		end

		// Word clamp, even lanes overflow and odd lanes underflow
		base = {jitter(16'h0100), jitter(16'hff00), jitter(16'h0100), jitter(16'hff00)};
		load_lanes(base, 64'hffd0_0030_ffd0_0030, 4'b0100);
		run_steps(8'd12);

		// Byte clamp on the low byte, high byte wraps freely
		base = ({$urandom, $urandom} & 64'hff00_ff00_ff00_ff00) | 64'h0040_00c0_0040_00c0;
		inc = ({$urandom, $urandom} & 64'hff00_ff00_ff00_ff00) | 64'h00e8_0018_00e8_0018;
		load_lanes(base, inc, 4'b0101);
		run_steps(8'd12);

		// Nibble mode wrapping, then with the low byte clamped
		load_lanes({$urandom, $urandom}, {$urandom, $urandom}, 4'b0010);
		run_steps(8'(1 + $urandom % 16));
		load_lanes(base, inc, 4'b0110);
		run_steps(8'd12);

		// Chained word lanes, fraction carry into the integer lane
		load_lanes({$urandom, $urandom}, {$urandom, $urandom}, 4'b1000);
		run_steps(8'd9);
		base = {16'h0002, jitter(16'h8000), 16'hfffe, jitter(16'h8000)};
		load_lanes(base, 64'hffff_9000_0000_9000, 4'b1100);
		run_steps(8'd10);

		// Zero count is dropped
		write_reg(REG_GO, 16'd0);
		repeat (6) @(posedge clk);

		// Second go and an increment change in the middle of a run
		load_lanes({$urandom, $urandom}, {$urandom, $urandom}, 4'b0000);
		write_reg(REG_GO, 16'd6);
		repeat (2) @(posedge clk);
		write_reg(REG_GO, 16'd3);
		write_reg(REG_INC2, 16'($urandom));
		wait_done(30);
		wait_idle(10);

		repeat (4) @(posedge clk);
		if (uut.u_assert.fail_seen) begin
			$display("FAIL %0t: assertion failure seen at end of run", $time);
			$display("test failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// Testbench clock and reset source, 10 ns period with reset held for the first 5 cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset released on the fifth rising edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
